// ==== verilog/ls_pkg.sv ====
package ls_pkg;

	// data and address width
	localparam int xlen = 32;

	// destination tag width
	localparam int tag_width = 5;

	// access size, low two bits of funct3
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_t;

	typedef enum logic {
		op_load  = 1'b0,
		op_store = 1'b1
	} ls_op_t;

	// sequencer states
	typedef enum logic [1:0] {
		st_idle    = 2'b00,
		st_wait    = 2'b01,
		st_access  = 2'b10,
		st_respond = 2'b11
	} seq_state_t;

endpackage

// ==== verilog/ls_req_if.sv ====
`timescale 1ns/100ps

interface ls_req_if import ls_pkg::*; ();

	logic                 held;
	ls_op_t               op;
	mem_size_t            size;
	logic                 is_unsigned;
	logic [xlen-1:0]      addr;
	logic [xlen-1:0]      store_data;
	logic [tag_width-1:0] tag;
	// frees the entry, driven by the sequencer
	logic                 release_entry;

	modport issue (
		output held, op, size, is_unsigned, addr, store_data, tag,
		input  release_entry
	);

	modport exec (
		input  held, op, size, is_unsigned, addr, store_data, tag,
		output release_entry
	);

endinterface

// ==== verilog/ls_issue.sv ====
`timescale 1ns/100ps

module ls_issue import ls_pkg::*; (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 issue_valid,
	input  logic                 operands_ready,
	input  ls_op_t               op,
	input  mem_size_t            size,
	input  logic                 is_unsigned,
	input  logic [tag_width-1:0] tag,
	input  logic [xlen-1:0]      base,
	input  logic [xlen-1:0]      offset,
	input  logic [xlen-1:0]      store_data,
	input  logic                 operand_valid,
	input  logic [xlen-1:0]      late_base,
	input  logic [xlen-1:0]      late_store_data,
	input  logic                 squash,
	output logic                 busy,
	ls_req_if.issue              req
);

	logic                 entry_valid;
	logic                 operands_present;
	logic                 accept;
	logic                 late_fill;
	ls_op_t               op_q;
	mem_size_t            size_q;
	logic                 is_unsigned_q;
	logic [tag_width-1:0] tag_q;
	logic [xlen-1:0]      offset_q;
	logic [xlen-1:0]      addr_q;
	logic [xlen-1:0]      store_data_q;

	// single entry, so a new issue only lands in an empty stage
	assign accept    = issue_valid && !entry_valid;
	assign late_fill = operand_valid && entry_valid && !operands_present;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			entry_valid      <= 1'b0;
			operands_present <= 1'b0;
		end else if (squash) begin
			entry_valid      <= 1'b0;
			operands_present <= 1'b0;
		end else if (accept) begin
			entry_valid      <= 1'b1;
			operands_present <= operands_ready;
		end else if (req.release_entry) begin
			entry_valid      <= 1'b0;
			operands_present <= 1'b0;
		end else if (late_fill) begin
			operands_present <= 1'b1;
		end
	end

	// offset comes in already sign extended to xlen
	always_ff @(posedge clock) begin
		if (accept) begin
			op_q          <= op;
			size_q        <= size;
			is_unsigned_q <= is_unsigned;
			tag_q         <= tag;
			offset_q      <= offset;
			addr_q        <= base + offset;
			store_data_q  <= store_data;
		end else if (late_fill) begin
			addr_q       <= late_base + offset_q;
			store_data_q <= late_store_data;
		end
	end

	assign busy            = entry_valid;
	assign req.held        = entry_valid && operands_present;
	assign req.op          = op_q;
	assign req.size        = size_q;
	assign req.is_unsigned = is_unsigned_q;
	assign req.addr        = addr_q;
	assign req.store_data  = store_data_q;
	assign req.tag         = tag_q;

endmodule

// ==== verilog/ls_sequencer.sv ====
`timescale 1ns/100ps

module ls_sequencer import ls_pkg::*; (
	input  logic    clock,
	input  logic    arst_n,
	input  logic    squash,
	ls_req_if.exec  req,
	input  logic    expired,
	output logic    start,
	output logic    mem_en,
	output logic    mem_we,
	output logic    done
);

	seq_state_t state;
	seq_state_t state_next;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next        = state;
		start             = 1'b0;
		mem_en            = 1'b0;
		mem_we            = 1'b0;
		done              = 1'b0;
		req.release_entry = 1'b0;
		case (state)
			st_idle: begin
				// timer loads on the same edge we enter st_wait
				if (req.held) begin
					start      = 1'b1;
					state_next = st_wait;
				end
			end
			st_wait: begin
				if (expired) begin
					state_next = st_access;
				end
			end
			st_access: begin
				mem_en     = 1'b1;
				mem_we     = (req.op == op_store);
				state_next = st_respond;
			end
			st_respond: begin
				// read data is registered by now
				done              = 1'b1;
				req.release_entry = 1'b1;
				state_next        = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
		// squash wins over any transition
		if (squash) begin
			state_next = st_idle;
		end
	end

endmodule

// ==== verilog/ls_wait_timer.sv ====
`timescale 1ns/100ps

module ls_wait_timer #(
	parameter int mem_wait = 2
) (
	input  logic clock,
	input  logic arst_n,
	input  logic start,
	input  logic squash,
	output logic expired
);

	localparam int cnt_width = (mem_wait > 1) ? $clog2(mem_wait + 1) : 1;

	logic                 running;
	logic [cnt_width-1:0] count;
	logic [cnt_width-1:0] count_next;

	assign count_next = count - 1'b1;

	// one cycle strobe while the count sits at zero
	assign expired = running && (count == '0);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			count   <= '0;
		end else if (squash) begin
			running <= 1'b0;
			count   <= '0;
		end else if (start) begin
			running <= 1'b1;
			count   <= cnt_width'(mem_wait);
		end else if (running) begin
			count <= count_next;
			if (expired) begin
				running <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/ls_data_mem.sv ====
`timescale 1ns/100ps

module ls_data_mem import ls_pkg::*; #(
	parameter int mem_words = 256
) (
	input  logic                         clock,
	input  logic                         mem_en,
	input  logic                         mem_we,
	input  logic [$clog2(mem_words)-1:0] word_addr,
	input  logic [xlen/8-1:0]            lane_mask,
	input  logic [xlen-1:0]              write_word,
	output logic [xlen-1:0]              read_word
);

	localparam int lanes = xlen / 8;

	logic [xlen-1:0] mem [mem_words];

	// write only the enabled byte lanes
	always_ff @(posedge clock) begin
		if (mem_en && mem_we) begin
			for (int i = 0; i < lanes; i++) begin
				if (lane_mask[i]) begin
					mem[word_addr][i*8 +: 8] <= write_word[i*8 +: 8];
				end
			end
		end
	end

	// registered read, whole word
	always_ff @(posedge clock) begin
		if (mem_en && !mem_we) begin
			read_word <= mem[word_addr];
		end
	end

endmodule

// ==== verilog/ls_load_align.sv ====
`timescale 1ns/100ps

module ls_load_align import ls_pkg::*; #(
	parameter int mem_words = 256
) (
	ls_req_if.exec                       req,
	input  logic [xlen-1:0]              read_word,
	output logic [$clog2(mem_words)-1:0] word_addr,
	output logic [xlen/8-1:0]            lane_mask,
	output logic [xlen-1:0]              write_word,
	output logic [xlen-1:0]              result
);

	logic [1:0]      lane_off;
	logic [xlen-1:0] shifted;

	// upper address bits wrap onto the memory
	assign word_addr = req.addr[$clog2(mem_words)+1:2];

	// misaligned low bits are dropped per size
	always_comb begin
		case (req.size)
			size_byte: begin
				lane_off   = req.addr[1:0];
				lane_mask  = 4'b0001 << lane_off;
				write_word = {4{req.store_data[7:0]}};
			end
			size_half: begin
				lane_off   = {req.addr[1], 1'b0};
				lane_mask  = 4'b0011 << lane_off;
				write_word = {2{req.store_data[15:0]}};
			end
			default: begin
				lane_off   = 2'b00;
				lane_mask  = 4'b1111;
				write_word = req.store_data;
			end
		endcase
	end

	assign shifted = read_word >> {lane_off, 3'b000};

	always_comb begin
		if (req.op == op_store) begin
			result = '0;
		end else begin
			case (req.size)
				size_byte: result = {{(xlen-8){shifted[7] & !req.is_unsigned}}, shifted[7:0]};
				size_half: result = {{(xlen-16){shifted[15] & !req.is_unsigned}}, shifted[15:0]};
				default:   result = shifted;
			endcase
		end
	end

endmodule

// ==== verilog/ls_unit_top.sv ====
`timescale 1ns/100ps

module ls_unit_top import ls_pkg::*; #(
	parameter int mem_words = 256,
	parameter int mem_wait  = 2
) (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 issue_valid,
	input  logic                 operands_ready,
	input  ls_op_t               op,
	input  mem_size_t            size,
	input  logic                 is_unsigned,
	input  logic [tag_width-1:0] tag,
	input  logic [xlen-1:0]      base,
	input  logic [xlen-1:0]      offset,
	input  logic [xlen-1:0]      store_data,
	input  logic                 operand_valid,
	input  logic [xlen-1:0]      late_base,
	input  logic [xlen-1:0]      late_store_data,
	input  logic                 squash,
	output logic                 busy,
	output logic                 done,
	output logic [tag_width-1:0] done_tag,
	output logic [xlen-1:0]      result
);

	logic                         start;
	logic                         expired;
	logic                         mem_en;
	logic                         mem_we;
	logic [$clog2(mem_words)-1:0] word_addr;
	logic [xlen/8-1:0]            lane_mask;
	logic [xlen-1:0]              write_word;
	logic [xlen-1:0]              read_word;

	ls_req_if req ();

	ls_issue u_issue (
		.clock           (clock),
		.arst_n          (arst_n),
		.issue_valid     (issue_valid),
		.operands_ready  (operands_ready),
		.op              (op),
		.size            (size),
		.is_unsigned     (is_unsigned),
		.tag             (tag),
		.base            (base),
		.offset          (offset),
		.store_data      (store_data),
		.operand_valid   (operand_valid),
		.late_base       (late_base),
		.late_store_data (late_store_data),
		.squash          (squash),
		.busy            (busy),
		.req             (req.issue)
	);

	ls_sequencer u_sequencer (
		.clock   (clock),
		.arst_n  (arst_n),
		.squash  (squash),
		.req     (req.exec),
		.expired (expired),
		.start   (start),
		.mem_en  (mem_en),
		.mem_we  (mem_we),
		.done    (done)
	);

	ls_wait_timer #(
		.mem_wait (mem_wait)
	) u_wait_timer (
		.clock   (clock),
		.arst_n  (arst_n),
		.start   (start),
		.squash  (squash),
		.expired (expired)
	);

	ls_data_mem #(
		.mem_words (mem_words)
	) u_data_mem (
		.clock      (clock),
		.mem_en     (mem_en),
		.mem_we     (mem_we),
		.word_addr  (word_addr),
		.lane_mask  (lane_mask),
		.write_word (write_word),
		.read_word  (read_word)
	);

	ls_load_align #(
		.mem_words (mem_words)
	) u_load_align (
		.req        (req.exec),
		.read_word  (read_word),
		.word_addr  (word_addr),
		.lane_mask  (lane_mask),
		.write_word (write_word),
		.result     (result)
	);

	// tag stays in the entry until release
	assign done_tag = req.tag;

endmodule

// ==== verification/ls_unit_tb.sv ====
`timescale 1ns/100ps

module ls_unit_tb import ls_pkg::*; ();

	localparam int mem_words = 256;
	localparam int mem_wait = 2;
	localparam int reset_cycles = 5;

	typedef struct {
		ls_op_t               op;
		mem_size_t            size;
		logic                 uns;
		logic [tag_width-1:0] tag;
		logic [xlen-1:0]      base;
		logic [xlen-1:0]      offset;
		logic [xlen-1:0]      data;
		logic                 late;
		int                   delay;
		logic                 squash;
	} row_t;

	logic                 clock;
	logic                 arst_n;
	logic                 issue_valid;
	logic                 operands_ready;
	ls_op_t               op;
	mem_size_t            size;
	logic                 is_unsigned;
	logic [tag_width-1:0] tag;
	logic [xlen-1:0]      base;
	logic [xlen-1:0]      offset;
	logic [xlen-1:0]      store_data;
	logic                 operand_valid;
	logic [xlen-1:0]      late_base;
	logic [xlen-1:0]      late_store_data;
	logic                 squash;
	logic                 busy;
	logic                 done;
	logic [tag_width-1:0] done_tag;
	logic [xlen-1:0]      result;

	row_t       rows[$];
	logic [7:0] model_mem [mem_words*4];
	int         check_count = 0;
	int         error_count = 0;
	int         cycle_count = 0;
	int         cycle_limit = 0;

	ls_unit_top #(
		.mem_words (mem_words),
		.mem_wait  (mem_wait)
	) DUT (
		.clock           (clock),
		.arst_n          (arst_n),
		.issue_valid     (issue_valid),
		.operands_ready  (operands_ready),
		.op              (op),
		.size            (size),
		.is_unsigned     (is_unsigned),
		.tag             (tag),
		.base            (base),
		.offset          (offset),
		.store_data      (store_data),
		.operand_valid   (operand_valid),
		.late_base       (late_base),
		.late_store_data (late_store_data),
		.squash          (squash),
		.busy            (busy),
		.done            (done),
		.done_tag        (done_tag),
		.result          (result)
	);

	always begin
		clock = 1'b0;
		#20;
		clock = 1'b1;
		#20;
	end

	// watchdog
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run exceeded %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
		end
	endtask

	task automatic next_drive_slot();
		@(posedge clock);
		#1;
	endtask

	task automatic add_row(input ls_op_t r_op, input mem_size_t r_size, input logic r_uns,
	                       input logic [31:0] r_base, input logic [31:0] r_offset,
	                       input logic [31:0] r_data, input logic r_late, input int r_delay,
	                       input logic r_squash);
		row_t r;
		r.op     = r_op;
		r.size   = r_size;
		r.uns    = r_uns;
		r.tag    = tag_width'(rows.size() * 7 + 3);
		r.base   = r_base;
		r.offset = r_offset;
		r.data   = r_data;
		r.late   = r_late;
		r.delay  = r_delay;
		r.squash = r_squash;
		rows.push_back(r);
	endtask

	// word fill value, mixes every address bit
	function automatic logic [31:0] fill_word(input int i);
		return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	// lane offset and byte count per access size
	function automatic int first_lane(input logic [31:0] addr, input mem_size_t sz);
		if (sz == size_byte) return int'(addr[1:0]);
		if (sz == size_half) return addr[1] ? 2 : 0;
		return 0;
	endfunction

	function automatic logic [31:0] expected_load(input logic [31:0] addr, input mem_size_t sz,
	                                              input logic uns);
		int         word;
		int         lane;
		logic [7:0] b;
		logic [15:0] h;
		word = int'((addr >> 2) % mem_words);
		lane = first_lane(addr, sz);
		b = model_mem[word*4 + lane];
		h = {model_mem[word*4 + lane + 1], b};
		if (sz == size_byte) return uns ? {24'h0, b} : {{24{b[7]}}, b};
		if (sz == size_half) return uns ? {16'h0, h} : {{16{h[15]}}, h};
		return {model_mem[word*4 + 3], model_mem[word*4 + 2], model_mem[word*4 + 1],
		        model_mem[word*4]};
	endfunction

	task automatic store_model(input logic [31:0] addr, input mem_size_t sz,
	                           input logic [31:0] data);
		int word;
		int lane;
		int n;
		word = int'((addr >> 2) % mem_words);
		lane = first_lane(addr, sz);
		n = (sz == size_byte) ? 1 : (sz == size_half) ? 2 : 4;
		for (int k = 0; k < n; k++) begin
			model_mem[word*4 + lane + k] = data[k*8 +: 8];
		end
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] addr;
		logic [31:0] expected;
		int          cycles;
		addr = r.base + r.offset;
		expected = (r.op == op_load) ? expected_load(addr, r.size, r.uns) : 32'h0;
		next_drive_slot();
		issue_valid    = 1'b1;
		operands_ready = !r.late;
		op             = r.op;
		size           = r.size;
		is_unsigned    = r.uns;
		tag            = r.tag;
		offset         = r.offset;
		// wrong early operands prove the late ones are used
		base           = r.late ? ~r.base : r.base;
		store_data     = r.late ? ~r.data : r.data;
		next_drive_slot();
		issue_valid    = 1'b0;
		operands_ready = 1'b0;
		if (r.late) begin
			for (int k = 0; k < r.delay; k++) begin
				@(negedge clock);
				check_value("done", done, 0);
				check_value("busy", busy, 1);
				next_drive_slot();
			end
			operand_valid   = 1'b1;
			late_base       = r.base;
			late_store_data = r.data;
			next_drive_slot();
			operand_valid   = 1'b0;
		end
		// now just past the capture edge
		if (r.squash) begin
			next_drive_slot();
			squash = 1'b1;
			next_drive_slot();
			squash = 1'b0;
			repeat (mem_wait + 4) begin
				@(negedge clock);
				check_value("done", done, 0);
			end
			check_value("busy", busy, 0);
		end else begin
			@(negedge clock);
			cycles = 0;
			while (!done) begin
				check_value("busy", busy, 1);
				@(negedge clock);
				cycles++;
			end
			check_value("busy", busy, 1);
			check_value("done_tag", done_tag, r.tag);
			check_value("result", result, expected);
			check_value("latency", 32'(cycles), 32'(mem_wait + 3));
			@(negedge clock);
			check_value("busy", busy, 0);
			check_value("done", done, 0);
			if (r.op == op_store) begin
				store_model(addr, r.size, r.data);
			end
		end
	endtask

	initial begin
		int max_late;
		arst_n          = 1'b0;
		issue_valid     = 1'b0;
		operands_ready  = 1'b0;
		op              = op_load;
		size            = size_word;
		is_unsigned     = 1'b0;
		tag             = '0;
		base            = '0;
		offset          = '0;
		store_data      = '0;
		operand_valid   = 1'b0;
		late_base       = '0;
		late_store_data = '0;
		squash          = 1'b0;

		// every word written through the DUT first
		for (int i = 0; i < mem_words; i++) begin
			add_row(op_store, size_word, 0, 32'(i * 4), 0, fill_word(i), 0, 0, 0);
		end
		add_row(op_store, size_word, 0, 32'h100, 32'h10, 32'hdead_beef, 0, 0, 0);
		add_row(op_load, size_word, 0, 32'h110, 32'h0, 0, 0, 0, 0);
		add_row(op_store, size_byte, 0, 32'h200, 0, 32'h1234_5681, 0, 0, 0);
		add_row(op_store, size_byte, 0, 32'h200, 1, 32'h1234_567f, 0, 0, 0);
		add_row(op_store, size_byte, 0, 32'h200, 2, 32'h1234_56c3, 0, 0, 0);
		add_row(op_store, size_byte, 0, 32'h200, 3, 32'h1234_5605, 0, 0, 0);
		for (int k = 0; k < 4; k++) begin
			add_row(op_load, size_byte, 0, 32'h200, 32'(k), 0, 0, 0, 0);
			add_row(op_load, size_byte, 1, 32'h200, 32'(k), 0, 0, 0, 0);
		end
		add_row(op_store, size_byte, 0, 32'h20c, 1, 32'h0000_00a7, 0, 0, 0);
		add_row(op_load, size_word, 0, 32'h20c, 0, 0, 0, 0, 0);
		add_row(op_store, size_half, 0, 32'h208, 0, 32'haaaa_8001, 0, 0, 0);
		add_row(op_store, size_half, 0, 32'h208, 2, 32'h5555_7ffe, 0, 0, 0);
		for (int k = 0; k < 2; k++) begin
			add_row(op_load, size_half, 0, 32'h208, 32'(k * 2), 0, 0, 0, 0);
			add_row(op_load, size_half, 1, 32'h208, 32'(k * 2), 0, 0, 0, 0);
		end
		add_row(op_load, size_word, 0, 32'h208, 0, 0, 0, 0, 0);
		add_row(op_store, size_half, 0, 32'h210, 2, 32'h0000_c0de, 0, 0, 0);
		add_row(op_load, size_word, 0, 32'h210, 0, 0, 0, 0, 0);
		add_row(op_load, size_half, 0, 32'h213, 0, 0, 0, 0, 0);
		add_row(op_load, size_byte, 0, 32'h204, 32'hffff_fffd, 0, 0, 0, 0);
		// late operands
		add_row(op_load, size_word, 0, 32'h100, 32'h10, 0, 1, 3, 0);
		add_row(op_store, size_byte, 0, 32'h300, 1, 32'h0000_00fe, 1, 1, 0);
		add_row(op_load, size_byte, 0, 32'h300, 1, 0, 1, 2, 0);
		add_row(op_load, size_word, 0, 32'h300, 0, 0, 1, 0, 0);
		// squashed stores leave memory alone
		add_row(op_store, size_word, 0, 32'h110, 0, 32'h1122_3344, 0, 0, 1);
		add_row(op_load, size_word, 0, 32'h110, 0, 0, 0, 0, 0);
		add_row(op_store, size_half, 0, 32'h208, 0, 32'h0000_1234, 0, 0, 1);
		add_row(op_load, size_half, 1, 32'h208, 0, 0, 0, 0, 0);

		max_late = 0;
		foreach (rows[i]) begin
			if (rows[i].late && rows[i].delay > max_late) max_late = rows[i].delay;
		end
		cycle_limit = rows.size() * (mem_wait + 3 + max_late + 4) + reset_cycles;

		repeat (reset_cycles) @(posedge clock);
		#1;
		arst_n = 1'b1;
		@(negedge clock);
		check_value("busy", busy, 0);
		check_value("done", done, 0);

		foreach (rows[i]) begin
			apply_row(rows[i]);
		end

		$display("checks=%0d errors=%0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
verilog/ls_pkg.sv
verilog/ls_req_if.sv
verilog/ls_issue.sv
verilog/ls_sequencer.sv
verilog/ls_wait_timer.sv
verilog/ls_data_mem.sv
verilog/ls_load_align.sv
verilog/ls_unit_top.sv
verification/ls_unit_tb.sv

// ==== Makefile ====
TOP := ls_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir
